/* vlog.f */
hw/card_grid_pkg.sv
hw/pixel_if.sv
hw/card_image_rom.sv
hw/card_drawer.sv
hw/draw_sequencer.sv
hw/card_grid_top.sv
tb/card_grid_chk.sv
tb/card_grid_tb.sv

/* Bender.yml */
package:
  name: card_grid

dependencies: {}

sources:
  # design, package first
  - files:
      - hw/card_grid_pkg.sv
      - hw/pixel_if.sv
      - hw/card_image_rom.sv
      - hw/card_drawer.sv
      - hw/draw_sequencer.sv
      - hw/card_grid_top.sv

  # testbench and bound checker
  - target: test
    files:
      - tb/card_grid_chk.sv
      - tb/card_grid_tb.sv

/* tb/card_grid_tb.sv */
`default_nettype none

module card_grid_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {PULSE_START, RANDOM_START, HELD_START} start_mode_t;

    logic                  CLOCK_50;
    logic                  reset;
    logic                  draw_start;
    card_grid_pkg::x_t     pixel_x;
    card_grid_pkg::y_t     pixel_y;
    card_grid_pkg::color_t pixel_color;
    logic                  pixel_write;
    logic                  busy;

    int     pass_writes  = 16 * 64 * 64;
    int     pass_timeout = 70000;   // one pass takes a little over 65k cycles
    integer seed         = 32'hb3d7;

    // reference stream position
    logic   exp_image;
    int     write_count;
    int     passes_done;
    string  test_name;

    card_grid_top u_card_grid_top (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .draw_start  (draw_start),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_color (pixel_color),
        .pixel_write (pixel_write),
        .busy        (busy)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    // a failed property in the bound checker ends the run at once
    always @(u_card_grid_top.u_card_grid_chk.fail_count) begin
        if (u_card_grid_top.u_card_grid_chk.fail_count != 0) begin
            $display("Simulation failed");
            $fatal(1, "assertion failed in the bound checker");
        end
    end

    // n counts writes in card order and row-major inside a card
    function automatic int model_x(input int n);
        int card;
        card = n / 4096;
        return 108 + (card % 4) * 56 + (n % 64);
    endfunction

    function automatic int model_y(input int n);
        int card;
        card = n / 4096;
        return 56 + (card / 4) * 56 + ((n % 4096) / 64);
    endfunction

    function automatic int model_color(input logic image, input int n);
        int row;
        int col;
        row = (n % 4096) / 64;
        col = n % 64;
        if (image == 1'b0)
            return ((row >> 3) << 6) | ((col >> 3) << 3) | ((row ^ col) & 7);
        if (((row >> 3) & 1) != ((col >> 3) & 1))
            return 9'h1FF;
        return 9'h007;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: %s expected %0d, actual %0d",
                     test_name, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s: gave up waiting for %s", test_name, what);
        $display("Simulation failed");
        $fatal(1, "wait loop timed out");
    endtask

    // outputs are looked at on the falling edge where they are settled
    task automatic sample_cycle();
        @(negedge CLOCK_50);
        if (pixel_write) begin
            check_value("pixel x", model_x(write_count), pixel_x);
            check_value("pixel y", model_y(write_count), pixel_y);
            check_value("pixel color", model_color(exp_image, write_count), pixel_color);
            write_count++;
            if (write_count == pass_writes) begin
                write_count = 0;
                exp_image   = ~exp_image;   // next pass uses the other image
                passes_done++;
            end
        end
    endtask

    task automatic apply_reset(input int n_cycles);
        reset      = 1'b1;
        draw_start = 1'b0;
        for (int i = 0; i < n_cycles; i++) begin
            @(negedge CLOCK_50);
            check_value("pixel_write in reset", 0, pixel_write);
            check_value("busy in reset", 0, busy);
        end
        reset       = 1'b0;
        exp_image   = 1'b0;
        write_count = 0;
    endtask

    task automatic expect_idle(input int n_cycles);
        for (int i = 0; i < n_cycles; i++) begin
            sample_cycle();
            check_value("pixel_write while idle", 0, pixel_write);
            check_value("busy while idle", 0, busy);
        end
    endtask

    // start from idle and follow the pass to its last write
    task automatic run_pass(input start_mode_t mode);
        int          cycles;
        int          first_write;
        int          start_passes;
        logic [31:0] rnd;
        start_passes = passes_done;
        cycles       = 0;
        first_write  = 0;
        check_value("busy before start", 0, busy);
        draw_start = 1'b1;
        while (passes_done == start_passes) begin
            sample_cycle();
            cycles++;
            if (cycles == 1)
                check_value("busy after start", 1, busy);
            if (pixel_write && first_write == 0)
                first_write = cycles;
            if (cycles > pass_timeout)
                report_timeout("the end of a pass");
            case (mode)
                PULSE_START:  draw_start = 1'b0;
                HELD_START:   draw_start = 1'b1;
                default: begin
                    rnd        = $random(seed);
                    draw_start = rnd[0];
                end
            endcase
        end
        check_value("first write delay", 3, first_write);
        check_value("busy at last write", 1, busy);
        sample_cycle();
        draw_start = 1'b0;
        check_value("busy after last card", 0, busy);
    endtask

    task automatic test_idle_after_reset();
        test_name = "idle_after_reset";
        expect_idle(200);
    endtask

    task automatic test_first_pass();
        test_name = "first_pass";
        run_pass(PULSE_START);
        expect_idle(20);
    endtask

    task automatic test_second_pass();
        test_name = "second_pass";
        run_pass(PULSE_START);
        expect_idle(20);
    endtask

    task automatic test_start_during_pass();
        test_name = "start_during_pass";
        run_pass(RANDOM_START);
        expect_idle(50);        // no second pass from the random starts
        run_pass(HELD_START);
        expect_idle(50);
    endtask

    task automatic test_reset_mid_pass();
        int cycles;
        test_name = "reset_mid_pass";
        run_pass(PULSE_START);  // leaves image 1 selected
        draw_start = 1'b1;
        cycles     = 0;
        while (write_count < 10000) begin
            sample_cycle();
            draw_start = 1'b0;
            cycles++;
            if (cycles > pass_timeout)
                report_timeout("writes before the reset");
        end
        apply_reset(16);
        expect_idle(20);
        run_pass(PULSE_START);  // model is back on image 0
        expect_idle(20);
    endtask

    initial begin
        reset       = 1'b1;
        draw_start  = 1'b0;
        exp_image   = 1'b0;
        write_count = 0;
        passes_done = 0;
        test_name   = "reset";
        apply_reset(16);
        test_idle_after_reset();
        test_first_pass();
        test_second_pass();
        test_start_during_pass();
        test_reset_mid_pass();
        if (u_card_grid_top.u_card_grid_chk.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "assertions failed in the bound checker");
        end
    end

endmodule

`default_nettype wire

/* tb/card_grid_chk.sv */
`default_nettype none

// protocol properties of the card grid top level
module card_grid_chk (
    input wire                                 CLOCK_50,
    input wire                                 reset,
    input wire                                 busy,
    input wire                                 pixel_write,
    input wire card_grid_pkg::x_t              pixel_x,
    input wire card_grid_pkg::y_t              pixel_y,
    input wire [card_grid_pkg::N_CARDS-1:0]    draw
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;     // failed properties so far, watched by the testbench

    a_write_busy: assert property (@(posedge CLOCK_50) disable iff (reset)
        pixel_write |-> busy)
    else begin
        $error("pixel write seen while not busy");
        fail_count++;
    end

    // a draw strobe leads to the card's first write two cycles later
    a_draw_write: assert property (@(posedge CLOCK_50) disable iff (reset)
        (|draw) |-> ##2 pixel_write)
    else begin
        $error("no pixel write two cycles after a draw strobe");
        fail_count++;
    end

    // grid spans 108..339 in x and 56..287 in y
    a_x_range: assert property (@(posedge CLOCK_50) disable iff (reset)
        pixel_write |-> (pixel_x >= 108 && pixel_x <= 339))
    else begin
        $error("pixel x outside the grid");
        fail_count++;
    end

    a_y_range: assert property (@(posedge CLOCK_50) disable iff (reset)
        pixel_write |-> (pixel_y >= 56 && pixel_y <= 287))
    else begin
        $error("pixel y outside the grid");
        fail_count++;
    end

    a_reset_idle: assert property (@(posedge CLOCK_50)
        reset |=> (!busy && !pixel_write))
    else begin
        $error("busy or pixel write high after reset");
        fail_count++;
    end

endmodule

bind card_grid_top card_grid_chk u_card_grid_chk (
    .CLOCK_50    (CLOCK_50),
    .reset       (reset),
    .busy        (busy),
    .pixel_write (pixel_write),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .draw        (draw)
);

`default_nettype wire

/* hw/card_grid_top.sv */
`default_nettype none

module card_grid_top (
    input  wire                    CLOCK_50,
    input  wire                    reset,
    input  wire                    draw_start,
    output card_grid_pkg::x_t      pixel_x,
    output card_grid_pkg::y_t      pixel_y,
    output card_grid_pkg::color_t  pixel_color,
    output logic                   pixel_write,
    output logic                   busy
);

    logic [card_grid_pkg::N_CARDS-1:0] draw;
    logic [card_grid_pkg::N_CARDS-1:0] done;
    logic [card_grid_pkg::N_CARDS-1:0] card_write;
    card_grid_pkg::card_idx_t          card_idx;
    logic                              image_sel;
    card_grid_pkg::img_addr_t          rom_addr;
    card_grid_pkg::color_t             rom_color;

    // per card streams, gathered so they can be indexed by card_idx
    card_grid_pkg::img_addr_t card_addr  [card_grid_pkg::N_CARDS];
    card_grid_pkg::x_t        card_x     [card_grid_pkg::N_CARDS];
    card_grid_pkg::y_t        card_y     [card_grid_pkg::N_CARDS];
    card_grid_pkg::color_t    card_color [card_grid_pkg::N_CARDS];

    pixel_if pix_bus [card_grid_pkg::N_CARDS] ();

    draw_sequencer u_draw_sequencer (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .draw_start (draw_start),
        .done       (done),
        .draw       (draw),
        .card_idx   (card_idx),
        .image_sel  (image_sel),
        .busy       (busy)
    );

    card_image_rom u_card_image_rom (
        .CLOCK_50 (CLOCK_50),
        .addr     (rom_addr),
        .color    (rom_color)
    );

    for (genvar g = 0; g < card_grid_pkg::N_CARDS; g++) begin : g_card
        card_drawer #(
            .CARD_INDEX (g)
        ) u_card_drawer (
            .CLOCK_50  (CLOCK_50),
            .reset     (reset),
            .draw      (draw[g]),
            .image_sel (image_sel),
            .rom_color (rom_color),
            .rom_addr  (card_addr[g]),
            .done      (done[g]),
            .pix       (pix_bus[g])
        );

        assign card_x[g]     = pix_bus[g].x;
        assign card_y[g]     = pix_bus[g].y;
        assign card_color[g] = pix_bus[g].color;
        assign card_write[g] = pix_bus[g].write;
    end

    // only the card at card_idx is active, the rest sit idle
    assign rom_addr    = card_addr[card_idx];
    assign pixel_x     = card_x[card_idx];
    assign pixel_y     = card_y[card_idx];
    assign pixel_color = card_color[card_idx];
    assign pixel_write = card_write[card_idx];

endmodule

`default_nettype wire

/* hw/draw_sequencer.sv */
`default_nettype none

// steps the drawers one after another, then flips the image
module draw_sequencer (
    input  wire                                CLOCK_50,
    input  wire                                reset,
    input  wire                                draw_start,
    input  wire [card_grid_pkg::N_CARDS-1:0]   done,
    output logic [card_grid_pkg::N_CARDS-1:0]  draw,
    output card_grid_pkg::card_idx_t           card_idx,
    output logic                               image_sel,
    output logic                               busy
);

    logic push;         // one cycle go for the card at card_idx
    logic last_card;

    assign last_card = (card_idx == card_grid_pkg::card_idx_t'(card_grid_pkg::N_CARDS - 1));

    always_comb begin
        draw           = '0;
        draw[card_idx] = push;
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            busy      <= 1'b0;
            push      <= 1'b0;
            card_idx  <= '0;
            image_sel <= 1'b0;
        end else begin
            push <= 1'b0;
            if (!busy) begin
                if (draw_start) begin       // only looked at while idle
                    busy     <= 1'b1;
                    card_idx <= '0;
                    push     <= 1'b1;
                end
            end else if (done[card_idx]) begin
                if (last_card) begin
                    busy      <= 1'b0;
                    card_idx  <= '0;
                    image_sel <= ~image_sel;
                end else begin
                    card_idx <= card_idx + 1'b1;
                    push     <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/card_drawer.sv */
`default_nettype none

// scans one 64x64 card area and emits a pixel write per position
module card_drawer #(
    parameter int CARD_INDEX = 0
) (
    input  wire                         CLOCK_50,
    input  wire                         reset,
    input  wire                         draw,
    input  wire                         image_sel,
    input  wire card_grid_pkg::color_t  rom_color,
    output card_grid_pkg::img_addr_t    rom_addr,
    output logic                        done,
    pixel_if.source                     pix
);

    logic [card_grid_pkg::SCAN_W-1:0]    scan;     // {row, col}
    logic [card_grid_pkg::CARD_BITS-1:0] row;
    logic [card_grid_pkg::CARD_BITS-1:0] col;
    logic                                active;
    logic                                last_pix;
    logic                                wr_q;
    logic                                done_q;
    card_grid_pkg::x_t                   x_q;
    card_grid_pkg::y_t                   y_q;

    assign row      = scan[card_grid_pkg::SCAN_W-1:card_grid_pkg::CARD_BITS];
    assign col      = scan[card_grid_pkg::CARD_BITS-1:0];
    assign last_pix = (scan == card_grid_pkg::SCAN_LAST);

    // address stage
    assign rom_addr = {image_sel, scan};

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            active <= 1'b0;
            scan   <= '0;
            wr_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            wr_q   <= active;
            done_q <= active && last_pix;
            if (draw) begin
                active <= 1'b1;
                scan   <= '0;
            end else if (active) begin
                scan <= scan + 1'b1;
                if (last_pix)
                    active <= 1'b0;
            end
        end
    end

    // write stage, screen position lines up with the rom output
    always_ff @(posedge CLOCK_50) begin
        x_q <= card_grid_pkg::card_origin_x(CARD_INDEX) + card_grid_pkg::x_t'(col);
        y_q <= card_grid_pkg::card_origin_y(CARD_INDEX) + card_grid_pkg::y_t'(row);
    end

    assign pix.x     = x_q;
    assign pix.y     = y_q;
    assign pix.color = rom_color;
    assign pix.write = wr_q;
    assign done      = done_q;      // same cycle as the last write

endmodule

`default_nettype wire

/* hw/card_image_rom.sv */
`default_nettype none

// both card images, address is {image, row, col}
module card_image_rom (
    input  wire                       CLOCK_50,
    input  wire card_grid_pkg::img_addr_t addr,
    output card_grid_pkg::color_t     color
);

    card_grid_pkg::color_t mem [card_grid_pkg::ROM_DEPTH];

    // contents come from the image rule, built once at elaboration
    initial begin
        card_grid_pkg::img_addr_t a;
        for (int i = 0; i < card_grid_pkg::ROM_DEPTH; i++) begin
            a = card_grid_pkg::img_addr_t'(i);
            mem[i] = card_grid_pkg::card_art_pixel(
                a[card_grid_pkg::ADDR_W-1],
                a[card_grid_pkg::SCAN_W-1:card_grid_pkg::CARD_BITS],
                a[card_grid_pkg::CARD_BITS-1:0]
            );
        end
    end

    always_ff @(posedge CLOCK_50) begin
        color <= mem[addr];             // one cycle read latency
    end

endmodule

`default_nettype wire

/* hw/pixel_if.sv */
`default_nettype none

// pixel write stream of one card drawer
interface pixel_if;

    card_grid_pkg::x_t     x;
    card_grid_pkg::y_t     y;
    card_grid_pkg::color_t color;
    logic                  write;      // x, y and color only valid with this

    modport source (
        output x, y, color, write
    );

    modport sink (
        input x, y, color, write
    );

endinterface

`default_nettype wire

/* hw/card_grid_pkg.sv */
`default_nettype none

package card_grid_pkg;

    localparam int COLOR_W   = 9;
    localparam int X_W       = 10;
    localparam int Y_W       = 9;
    localparam int CARD_BITS = 6;               // per card coordinate
    localparam int CARD_SIZE = 64;
    localparam int ROWS      = 4;
    localparam int COLS      = 4;
    localparam int N_CARDS   = ROWS * COLS;
    localparam int IDX_W     = 4;
    localparam int SCAN_W    = 2 * CARD_BITS;   // row above column
    localparam int ADDR_W    = 1 + SCAN_W;      // image select on top
    localparam int ROM_DEPTH = 1 << ADDR_W;

    // card origins, pitch is smaller than the card so neighbours overlap by 8
    localparam int START_X = 108;
    localparam int START_Y = 56;
    localparam int GAP_X   = 56;
    localparam int GAP_Y   = 56;

    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(CARD_SIZE * CARD_SIZE - 1);

    typedef logic [COLOR_W-1:0] color_t;
    typedef logic [X_W-1:0]     x_t;
    typedef logic [Y_W-1:0]     y_t;
    typedef logic [IDX_W-1:0]   card_idx_t;
    typedef logic [ADDR_W-1:0]  img_addr_t;

    function automatic x_t card_origin_x(input int index);
        return x_t'(START_X + (index % COLS) * GAP_X);
    endfunction

    function automatic y_t card_origin_y(input int index);
        return y_t'(START_Y + (index / COLS) * GAP_Y);
    endfunction

    // image 0 is a shaded gradient, image 1 a checkerboard of 8x8 squares
    function automatic color_t card_art_pixel(input logic image,
                                              input logic [CARD_BITS-1:0] row,
                                              input logic [CARD_BITS-1:0] col);
        if (!image)
            return {row[5:3], col[5:3], row[2:0] ^ col[2:0]};
        return (row[3] != col[3]) ? 9'h1FF : 9'h007;
    endfunction

endpackage

`default_nettype wire
